// File: cpu_input.txt
# P addr word is a program or data word, I word is the inport value
# E test word is an expected outport word in order, test 1 arith 2 mul 3 mem 4 branch 5 inport
I 12345678
P 000 6080006C
P 001 6107FFF9
P 002 19890000
P 003 B9800000
P 004 22090000
P 005 BA000000
P 006 2A890000
P 007 BA800000
P 008 33090000
P 009 BB000000
P 00A B9000000
P 00B 6384F2C0
P 00C 640249F0
P 00D 7BC00000
P 00E C4800000
P 00F CD000000
P 010 BC800000
P 011 BD000000
P 012 65800100
P 013 12580010
P 014 06580010
P 015 BE000000
P 016 06800120
P 017 BE800000
P 018 90000002
P 019 67000BAD
P 01A BF000000
P 01B 67000111
P 01C BF000000
P 01D 90800002
P 01E 67000222
P 01F BF000000
P 020 98880002
P 021 67000BAD
P 022 BF000000
P 023 67000333
P 024 BF000000
P 025 98080002
P 026 67000444
P 027 BF000000
P 028 B7800000
P 029 67F80005
P 02A BF800000
P 02B D8000000
P 120 CAFEF00D
E 1 00000065
E 1 00000073
E 1 00000068
E 1 FFFFFFFD
E 1 FFFFFFF9
E 2 FFFFFFF9
E 2 03DC5400
E 3 00000073
E 3 CAFEF00D
E 4 00000111
E 4 00000222
E 4 00000333
E 4 00000444
E 5 1234567D

// File: sim.f
isa_pkg.sv
ctrl_pkg.sv
ctrl_if.sv
mem_if.sv
alu.sv
datapath.sv
control_unit.sv
ram.sv
cpu_top.sv
tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int MEM_ADDR_W   = 9;
    localparam int HALT_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  prog_we;
    logic [MEM_ADDR_W-1:0] prog_addr;
    logic [31:0]           prog_data;
    logic [31:0]           inport_in;
    logic [31:0]           outport_data;
    logic                  out_valid;
    logic                  halted;

    // Contents of the input file
    logic [31:0] load_addr_q [$];
    logic [31:0] load_data_q [$];
    logic [31:0] exp_word_q  [$];
    int          exp_test_q  [$];
    logic [31:0] inport_value;

    logic [31:0] seen_q [$];
    int          errors;
    bit          file_ok;
    bit          halt_seen;
    bit          late_pulse;

    cpu_top #(.MEM_ADDR_W(MEM_ADDR_W)) i_cpu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .inport_in    (inport_in),
        .outport_data (outport_data),
        .out_valid    (out_valid),
        .halted       (halted)
    );

    always #10 clk = ~clk;

    // Capture outport words away from the rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            seen_q.push_back(outport_data);
            if (halted) begin
                late_pulse = 1'b1;
            end
        end
    end

    function automatic string test_name(input int group);
        case (group)
            1:       return "arithmetic";
            2:       return "multiply";
            3:       return "memory";
            4:       return "branch";
            5:       return "input_port";
            default: return "unknown";
        endcase
    endfunction

    task automatic read_input_file(output bit ok);
        int          fd;
        int          code;
        int          ch;
        int          group;
        logic [7:0]  tag;
        logic [31:0] addr;
        logic [31:0] value;
        ok = 1'b0;
        fd = $fopen("cpu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_input.txt");
            errors++;
            return;
        end
        code = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            case (tag)
                "P": begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    load_addr_q.push_back(addr);
                    load_data_q.push_back(value);
                end
                "I": begin
                    code = $fscanf(fd, "%h", value);
                    inport_value = value;
                end
                "E": begin
                    code = $fscanf(fd, "%d %h", group, value);
                    exp_test_q.push_back(group);
                    exp_word_q.push_back(value);
                end
                default: begin
                    // Comment or unknown line, skip to its end
                    if (tag != "#") begin
                        $display("unknown line tag %c in cpu_input.txt", tag);
                        errors++;
                    end
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
            endcase
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
        if (load_addr_q.size() == 0 || exp_word_q.size() == 0) begin
            $display("cpu_input.txt holds no program or no expected words");
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic check_idle_state();
        if (halted !== 1'b0) begin
            $display("error reset halted expected 0 actual %0b", halted);
            errors++;
        end
        if (out_valid !== 1'b0) begin
            $display("error reset out_valid expected 0 actual %0b", out_valid);
            errors++;
        end
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < load_addr_q.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = load_addr_q[i][MEM_ADDR_W-1:0];
            prog_data = load_data_q[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
    endtask

    task automatic wait_for_halt(output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (halted === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_outport_words();
        int n;
        int i;
        if (seen_q.size() != exp_word_q.size()) begin
            $display("error ending out_valid pulses expected %0d actual %0d",
                     exp_word_q.size(), seen_q.size());
            errors++;
        end
        n = (seen_q.size() < exp_word_q.size()) ? seen_q.size() : exp_word_q.size();
        for (i = 0; i < n; i++) begin
            if (seen_q[i] !== exp_word_q[i]) begin
                $display("error %s word %0d expected %08h actual %08h",
                         test_name(exp_test_q[i]), i, exp_word_q[i], seen_q[i]);
                errors++;
            end
        end
        if (late_pulse) begin
            $display("out_valid pulsed after halted rose");
            errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        inport_in    = '0;
        inport_value = '0;
        errors       = 0;
        halt_seen    = 1'b0;
        late_pulse   = 1'b0;

        read_input_file(file_ok);
        inport_in = inport_value;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_state();

        if (file_ok) begin
            load_program();
            run = 1'b1;
            wait_for_halt(halt_seen);
            if (halt_seen) begin
                // Window to catch any pulse after halt
                repeat (DRAIN_CYCLES) @(negedge clk);
                check_outport_words();
            end else begin
                $display("halted never rose within %0d cycles", HALT_TIMEOUT);
                errors++;
            end
        end

        $display("%0d outport words seen, %0d expected, %0d errors",
                 seen_q.size(), exp_word_q.size(), errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_ADDR_W = 9
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  prog_we,
    input  logic [MEM_ADDR_W-1:0] prog_addr,
    input  isa_pkg::word_t        prog_data,
    input  isa_pkg::word_t        inport_in,
    output isa_pkg::word_t        outport_data,
    output logic                  out_valid,
    output logic                  halted
);

    ctrl_if ctl ();
    mem_if #(.MEM_ADDR_W(MEM_ADDR_W)) mem ();

    logic [63:0]    alu_result;
    isa_pkg::word_t alu_a;
    isa_pkg::word_t bus;
    logic           load_we;

    // Program loading only while stopped
    assign load_we = prog_we & ~run;

    control_unit i_control_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .ctl    (ctl.ctrl),
        .halted (halted)
    );

    datapath i_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctl          (ctl.dp),
        .mem          (mem.master),
        .alu_result   (alu_result),
        .alu_a        (alu_a),
        .bus          (bus),
        .inport_in    (inport_in),
        .outport_data (outport_data),
        .out_valid    (out_valid)
    );

    alu i_alu (
        .alu_op (ctl.alu_op),
        .a      (alu_a),
        .b      (bus),
        .result (alu_result)
    );

    ram #(.MEM_ADDR_W(MEM_ADDR_W)) i_ram (
        .clk       (clk),
        .mem       (mem.slave),
        .prog_we   (load_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

// File: ram.sv
`timescale 1ns/1ps

module ram #(
    parameter int MEM_ADDR_W = 9
) (
    input  logic                  clk,
    mem_if.slave                  mem,
    input  logic                  prog_we,
    input  logic [MEM_ADDR_W-1:0] prog_addr,
    input  isa_pkg::word_t        prog_data
);

    isa_pkg::word_t words [2**MEM_ADDR_W];

    always_ff @(posedge clk) begin
        // Program loading has priority
        if (prog_we) begin
            words[prog_addr] <= prog_data;
        end else if (mem.we) begin
            words[mem.addr] <= mem.wdata;
        end
        mem.rdata <= words[mem.addr];
    end

    assert property (@(posedge clk) !(prog_we && mem.we));

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    ctrl_if.ctrl ctl,
    output logic halted
);

    ctrl_pkg::state_t state;
    ctrl_pkg::state_t state_nxt;
    logic last_step;
    logic halt_step;

    function automatic isa_pkg::alu_op_t alu_for(input isa_pkg::opcode_t op);
        case (op)
            isa_pkg::OP_SUB: return isa_pkg::ALU_SUB;
            isa_pkg::OP_AND: return isa_pkg::ALU_AND;
            isa_pkg::OP_OR:  return isa_pkg::ALU_OR;
            isa_pkg::OP_MUL: return isa_pkg::ALU_MUL;
            default:         return isa_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctl.bus_src = ctrl_pkg::SRC_GPR;
        ctl.gpr_sel = ctrl_pkg::SEL_RA;
        ctl.alu_op  = alu_for(ctl.ir_op);
        {ctl.gpr_in, ctl.base_addr, ctl.y_in, ctl.z_in, ctl.hi_in, ctl.lo_in} = '0;
        {ctl.pc_in, ctl.ir_in, ctl.mar_in, ctl.mdr_in, ctl.mdr_read} = '0;
        {ctl.mem_wr, ctl.con_in, ctl.out_in} = '0;
        last_step = 1'b0;
        halt_step = 1'b0;
        case (state)
            // Fetch
            ctrl_pkg::S_F0: begin
                ctl.bus_src = ctrl_pkg::SRC_PC;
                ctl.alu_op  = isa_pkg::ALU_INC;
                ctl.mar_in  = 1'b1;
                ctl.z_in    = 1'b1;
            end
            ctrl_pkg::S_F1: begin
                ctl.bus_src  = ctrl_pkg::SRC_ZLO;
                ctl.pc_in    = 1'b1;
                ctl.mdr_read = 1'b1;
                ctl.mdr_in   = 1'b1;
            end
            ctrl_pkg::S_F2: begin
                ctl.bus_src = ctrl_pkg::SRC_MDR;
                ctl.ir_in   = 1'b1;
            end
            ctrl_pkg::S_E0: begin
                case (ctl.ir_op)
                    isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR: begin
                        ctl.gpr_sel = ctrl_pkg::SEL_RB;
                        ctl.y_in    = 1'b1;
                    end
                    isa_pkg::OP_MUL: ctl.y_in = 1'b1;
                    isa_pkg::OP_ADDI, isa_pkg::OP_LD, isa_pkg::OP_ST: begin
                        ctl.gpr_sel   = ctrl_pkg::SEL_RB;
                        ctl.base_addr = 1'b1;
                        ctl.y_in      = 1'b1;
                    end
                    isa_pkg::OP_BRZR, isa_pkg::OP_BRNZ: ctl.con_in = 1'b1;
                    isa_pkg::OP_IN: begin
                        ctl.bus_src = ctrl_pkg::SRC_INPORT;
                        ctl.gpr_in  = 1'b1;
                        last_step   = 1'b1;
                    end
                    isa_pkg::OP_MFHI, isa_pkg::OP_MFLO: begin
                        ctl.bus_src = (ctl.ir_op == isa_pkg::OP_MFHI) ? ctrl_pkg::SRC_HI
                                                                       : ctrl_pkg::SRC_LO;
                        ctl.gpr_in  = 1'b1;
                        last_step   = 1'b1;
                    end
                    isa_pkg::OP_OUT: begin
                        ctl.out_in = 1'b1;
                        last_step  = 1'b1;
                    end
                    isa_pkg::OP_HALT: halt_step = 1'b1;
                    // Unknown opcodes act as a no-op
                    default: last_step = 1'b1;
                endcase
            end
            ctrl_pkg::S_E1: begin
                ctl.z_in = 1'b1;
                case (ctl.ir_op)
                    isa_pkg::OP_MUL:  ctl.gpr_sel = ctrl_pkg::SEL_RB;
                    isa_pkg::OP_ADDI, isa_pkg::OP_LD, isa_pkg::OP_ST:
                        ctl.bus_src = ctrl_pkg::SRC_CSIGN;
                    isa_pkg::OP_BRZR, isa_pkg::OP_BRNZ: begin
                        // PC into Y ahead of the target sum
                        ctl.z_in    = 1'b0;
                        ctl.bus_src = ctrl_pkg::SRC_PC;
                        ctl.y_in    = 1'b1;
                    end
                    default: ctl.gpr_sel = ctrl_pkg::SEL_RC;
                endcase
            end
            ctrl_pkg::S_E2: begin
                ctl.bus_src = ctrl_pkg::SRC_ZLO;
                case (ctl.ir_op)
                    isa_pkg::OP_MUL: ctl.lo_in = 1'b1;
                    isa_pkg::OP_LD, isa_pkg::OP_ST: ctl.mar_in = 1'b1;
                    isa_pkg::OP_BRZR, isa_pkg::OP_BRNZ: begin
                        ctl.bus_src = ctrl_pkg::SRC_CSIGN;
                        ctl.z_in    = 1'b1;
                    end
                    default: begin
                        ctl.gpr_in = 1'b1;
                        last_step  = 1'b1;
                    end
                endcase
            end
            ctrl_pkg::S_E3: begin
                case (ctl.ir_op)
                    isa_pkg::OP_MUL: begin
                        ctl.bus_src = ctrl_pkg::SRC_ZHI;
                        ctl.hi_in   = 1'b1;
                        last_step   = 1'b1;
                    end
                    isa_pkg::OP_LD: begin
                        ctl.mdr_read = 1'b1;
                        ctl.mdr_in   = 1'b1;
                    end
                    isa_pkg::OP_ST: ctl.mdr_in = 1'b1;
                    default: begin
                        // Taken branch loads the target from Z
                        ctl.bus_src = ctrl_pkg::SRC_ZLO;
                        ctl.pc_in   = ctl.con;
                        last_step   = 1'b1;
                    end
                endcase
            end
            ctrl_pkg::S_E4: begin
                if (ctl.ir_op == isa_pkg::OP_LD) begin
                    ctl.bus_src = ctrl_pkg::SRC_MDR;
                    ctl.gpr_in  = 1'b1;
                end else begin
                    ctl.mem_wr = 1'b1;
                end
                last_step = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            ctrl_pkg::S_IDLE: state_nxt = run ? ctrl_pkg::S_F0 : ctrl_pkg::S_IDLE;
            ctrl_pkg::S_F0:   state_nxt = ctrl_pkg::S_F1;
            ctrl_pkg::S_F1:   state_nxt = ctrl_pkg::S_F2;
            ctrl_pkg::S_F2:   state_nxt = ctrl_pkg::S_E0;
            ctrl_pkg::S_E0:   state_nxt = ctrl_pkg::S_E1;
            ctrl_pkg::S_E1:   state_nxt = ctrl_pkg::S_E2;
            ctrl_pkg::S_E2:   state_nxt = ctrl_pkg::S_E3;
            ctrl_pkg::S_E3:   state_nxt = ctrl_pkg::S_E4;
            default:          state_nxt = state;
        endcase
        if (last_step) state_nxt = ctrl_pkg::S_F0;
        if (halt_step) state_nxt = ctrl_pkg::S_HALT;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ctrl_pkg::S_IDLE;
            halted <= 1'b0;
        end else begin
            state  <= state_nxt;
            halted <= (state_nxt == ctrl_pkg::S_HALT);
        end
    end

    // One bus load per cycle
    // Z takes the ALU result and memory reads bypass the bus
    assert property (@(posedge clk) disable iff (!rst_n)
        $countones({ctl.gpr_in, ctl.y_in, ctl.hi_in, ctl.lo_in, ctl.pc_in, ctl.ir_in,
                    ctl.mar_in, ctl.mdr_in & ~ctl.mdr_read, ctl.con_in, ctl.out_in}) <= 1);

    // Halt holds until reset
    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted);

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic           clk,
    input  logic           rst_n,
    ctrl_if.dp             ctl,
    mem_if.master          mem,
    input  logic [63:0]    alu_result,
    output isa_pkg::word_t alu_a,
    output isa_pkg::word_t bus,
    input  isa_pkg::word_t inport_in,
    output isa_pkg::word_t outport_data,
    output logic           out_valid
);

    isa_pkg::word_t gpr [16];
    isa_pkg::word_t y, hi, lo, z_hi, z_lo;
    isa_pkg::word_t pc, ir, mar, mdr, inport_q;
    isa_pkg::word_t c_sign;
    isa_pkg::word_t gpr_bus;
    isa_pkg::imm_t  imm;
    isa_pkg::reg_idx_t gpr_idx;
    logic con_q;
    logic cond_met;

    // Select and encode
    always_comb begin
        case (ctl.gpr_sel)
            ctrl_pkg::SEL_RB: gpr_idx = ir[isa_pkg::RB_LSB +: $bits(isa_pkg::reg_idx_t)];
            ctrl_pkg::SEL_RC: gpr_idx = ir[isa_pkg::RC_LSB +: $bits(isa_pkg::reg_idx_t)];
            default:          gpr_idx = ir[isa_pkg::RA_LSB +: $bits(isa_pkg::reg_idx_t)];
        endcase
    end

    // R0 as a base address reads as zero
    assign gpr_bus = (ctl.base_addr && gpr_idx == '0) ? '0 : gpr[gpr_idx];

    assign imm    = ir[isa_pkg::IMM_W-1:0];
    assign c_sign = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm};

    always_comb begin
        case (ctl.bus_src)
            ctrl_pkg::SRC_GPR:    bus = gpr_bus;
            ctrl_pkg::SRC_HI:     bus = hi;
            ctrl_pkg::SRC_LO:     bus = lo;
            ctrl_pkg::SRC_ZHI:    bus = z_hi;
            ctrl_pkg::SRC_ZLO:    bus = z_lo;
            ctrl_pkg::SRC_PC:     bus = pc;
            ctrl_pkg::SRC_MDR:    bus = mdr;
            ctrl_pkg::SRC_INPORT: bus = inport_q;
            ctrl_pkg::SRC_CSIGN:  bus = c_sign;
            default:              bus = '0;
        endcase
    end

    // Branch test picked by the condition code
    always_comb begin
        case (ir[isa_pkg::RB_LSB +: 2])
            isa_pkg::CC_ZERO:    cond_met = (bus == '0);
            isa_pkg::CC_NONZERO: cond_met = (bus != '0);
            isa_pkg::CC_POS:     cond_met = !bus[31];
            default:             cond_met = bus[31];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                gpr[i] <= '0;
            end
        end else if (ctl.gpr_in) begin
            gpr[gpr_idx] <= bus;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {y, hi, lo, z_hi, z_lo} <= '0;
            {pc, ir, mar, mdr, inport_q} <= '0;
            outport_data <= '0;
            out_valid    <= 1'b0;
            con_q        <= 1'b0;
        end else begin
            if (ctl.y_in)   y  <= bus;
            if (ctl.hi_in)  hi <= bus;
            if (ctl.lo_in)  lo <= bus;
            if (ctl.pc_in)  pc <= bus;
            if (ctl.ir_in)  ir <= bus;
            if (ctl.mar_in) mar <= bus;
            if (ctl.z_in) begin
                z_hi <= alu_result[63:32];
                z_lo <= alu_result[31:0];
            end
            if (ctl.mdr_in) mdr <= ctl.mdr_read ? mem.rdata : bus;
            if (ctl.con_in) con_q <= cond_met;
            if (ctl.out_in) outport_data <= bus;
            out_valid <= ctl.out_in;
            inport_q  <= inport_in;
        end
    end

    assign alu_a     = y;
    assign ctl.ir_op = isa_pkg::opcode_t'(ir[isa_pkg::OP_LSB +: $bits(isa_pkg::opcode_t)]);
    assign ctl.con   = con_q;

    // RAM sees the MAR input while MAR loads, so the read lines up one cycle later
    assign mem.addr  = ctl.mar_in ? bus[$bits(mem.addr)-1:0] : mar[$bits(mem.addr)-1:0];
    assign mem.wdata = mdr;
    assign mem.we    = ctl.mem_wr;

    // Memory data only enters MDR on an MDR load
    assert property (@(posedge clk) disable iff (!rst_n) ctl.mdr_read |-> ctl.mdr_in);

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_t alu_op,
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    output logic [63:0]      result
);

    isa_pkg::word_t low;

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: low = a + b;
            isa_pkg::ALU_SUB: low = a - b;
            isa_pkg::ALU_AND: low = a & b;
            isa_pkg::ALU_OR:  low = a | b;
            isa_pkg::ALU_INC: low = b + 32'd1;
            default:          low = '0;
        endcase
    end

    always_comb begin
        if (alu_op == isa_pkg::ALU_MUL) begin
            // Low 64 bits of the sign-extended operands give the signed product
            result = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end else begin
            result = {{32{low[31]}}, low};
        end
    end

endmodule

// File: mem_if.sv
`timescale 1ns/1ps

interface mem_if #(
    parameter int MEM_ADDR_W = 9
);

    logic [MEM_ADDR_W-1:0] addr;
    isa_pkg::word_t        wdata;
    isa_pkg::word_t        rdata;
    logic                  we;

    modport master (output addr, output wdata, output we, input rdata);
    modport slave  (input addr, input wdata, input we, output rdata);

endinterface

// File: ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

    ctrl_pkg::bus_src_t bus_src;
    ctrl_pkg::gpr_sel_t gpr_sel;
    isa_pkg::alu_op_t   alu_op;

    // Register load strobes
    logic gpr_in, base_addr;
    logic y_in, z_in, hi_in, lo_in;
    logic pc_in, ir_in, mar_in;
    logic mdr_in, mdr_read, mem_wr;
    logic con_in, out_in;

    // Status back from the datapath
    isa_pkg::opcode_t ir_op;
    logic             con;

    modport ctrl (
        output bus_src, gpr_sel, alu_op,
        output gpr_in, base_addr, y_in, z_in, hi_in, lo_in,
        output pc_in, ir_in, mar_in, mdr_in, mdr_read, mem_wr,
        output con_in, out_in,
        input  ir_op, con
    );

    modport dp (
        input  bus_src, gpr_sel, alu_op,
        input  gpr_in, base_addr, y_in, z_in, hi_in, lo_in,
        input  pc_in, ir_in, mar_in, mdr_in, mdr_read, mem_wr,
        input  con_in, out_in,
        output ir_op, con
    );

endinterface

// File: ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        S_IDLE,
        S_F0,
        S_F1,
        S_F2,
        S_E0,
        S_E1,
        S_E2,
        S_E3,
        S_E4,
        S_HALT
    } state_t;

    // One source drives the shared bus at a time
    typedef enum logic [3:0] {
        SRC_GPR,
        SRC_HI,
        SRC_LO,
        SRC_ZHI,
        SRC_ZLO,
        SRC_PC,
        SRC_MDR,
        SRC_INPORT,
        SRC_CSIGN
    } bus_src_t;

    typedef enum logic [1:0] {
        SEL_RA,
        SEL_RB,
        SEL_RC
    } gpr_sel_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    localparam int WORD_W = 32;
    localparam int IMM_W  = 19;

    // Low bit of each instruction field
    localparam int OP_LSB = 27;
    localparam int RA_LSB = 23;
    localparam int RB_LSB = 19;
    localparam int RC_LSB = 15;

    // Branch condition codes, held in the low bits of the rb field
    localparam logic [1:0] CC_ZERO    = 2'd0;
    localparam logic [1:0] CC_NONZERO = 2'd1;
    localparam logic [1:0] CC_POS     = 2'd2;
    localparam logic [1:0] CC_NEG     = 2'd3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        reg_idx_t;
    typedef logic [IMM_W-1:0]  imm_t;

    typedef enum logic [4:0] {
        OP_LD   = 5'b00000,
        OP_ST   = 5'b00010,
        OP_ADD  = 5'b00011,
        OP_SUB  = 5'b00100,
        OP_AND  = 5'b00101,
        OP_OR   = 5'b00110,
        OP_ADDI = 5'b01100,
        OP_MUL  = 5'b01111,
        OP_BRZR = 5'b10010,
        OP_BRNZ = 5'b10011,
        OP_IN   = 5'b10110,
        OP_OUT  = 5'b10111,
        OP_MFHI = 5'b11000,
        OP_MFLO = 5'b11001,
        OP_HALT = 5'b11011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_MUL,
        ALU_INC
    } alu_op_t;

endpackage
